// File: Makefile
# Verilator build and run for the border statistics testbench

VERILATOR ?= verilator
TOP       ?= border_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= \*\* PASS \*\*

SOURCES := $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^$(PASS_MSG)$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
+incdir+verilog
verilog/border_pkg.sv
verilog/tag_if.sv
verilog/raster_tagger.sv
verilog/side_accumulator.sv
verilog/border_analyzer.sv
verilog/border_top.sv
tb/border_tb.sv

// File: tb/border_tb.sv
`include "border_cfg.svh"

module border_tb;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int FRAME_PIX   = `BORDER_FRAME_W * `BORDER_FRAME_H;
  localparam int PART_PIX    = 3000;
  localparam int MAX_GAP     = 3;
  // Each pixel costs at most a strobe, a gap and one read
  localparam int RUN_CYCLES  = (2 * FRAME_PIX + PART_PIX + 16) * (MAX_GAP + 2) + 12 * 140;
  localparam int TIMEOUT     = 2 * RUN_CYCLES * CLK_PERIOD;

  logic                      clk;
  logic                      rst_n;
  logic                      new_pixel;
  logic                      new_frame;
  logic [`BORDER_PIX_W-1:0]  bg_pixel;
  logic [`BORDER_ADDR_W-1:0] address;
  logic                      read;
  logic [31:0]               readdata;

  int seed   = 32'hea7a;
  int errors = 0;
  int checks = 0;

  // Reference statistics indexed by scale and side
  logic [`BORDER_PIX_W-1:0] m_min [4][4];
  logic [`BORDER_PIX_W-1:0] m_max [4][4];
  logic [`BORDER_SUM_W-1:0] m_sum [4][4];
  logic [`BORDER_CNT_W-1:0] m_cnt [4][4];
  int mx;  // Raster position of the next pixel
  int my;

  border_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .new_pixel (new_pixel),
    .new_frame (new_frame),
    .bg_pixel  (bg_pixel),
    .address   (address),
    .read      (read),
    .readdata  (readdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic model_clear();
    for (int k = 0; k < 4; k++) begin
      for (int s = 0; s < 4; s++) begin
        m_min[k][s] = '0;
        m_max[k][s] = '0;
        m_sum[k][s] = '0;
        m_cnt[k][s] = '0;
      end
    end
  endtask

  task automatic model_update(input int k, input int s, input logic [`BORDER_PIX_W-1:0] p);
    if (m_cnt[k][s] == '0) begin
      m_min[k][s] = p;
      m_max[k][s] = p;
    end else begin
      if (p < m_min[k][s])
        m_min[k][s] = p;
      if (p > m_max[k][s])
        m_max[k][s] = p;
    end
    m_sum[k][s] = m_sum[k][s] + `BORDER_SUM_W'(p);
    m_cnt[k][s] = m_cnt[k][s] + 1'b1;
  endtask

  task automatic model_pixel(input logic [`BORDER_PIX_W-1:0] p);
    int  ts;
    int  ox;
    int  oy;
    logic fits;
    for (int k = 0; k < `BORDER_SCALES; k++) begin
      ts   = 16 << k;  // Tile side in pixels
      fits = ((mx / ts + 1) * ts <= `BORDER_FRAME_W) &&
             ((my / ts + 1) * ts <= `BORDER_FRAME_H);
      ox   = (mx >> k) % 16;
      oy   = (my >> k) % 16;
      if (fits) begin
        if (oy == 0)
          model_update(k, int'(border_pkg::SIDE_TOP), p);
        if (oy == 15)
          model_update(k, int'(border_pkg::SIDE_BOTTOM), p);
        if (ox == 0)
          model_update(k, int'(border_pkg::SIDE_LEFT), p);
        if (ox == 15)
          model_update(k, int'(border_pkg::SIDE_RIGHT), p);
      end
    end
    if (mx == `BORDER_FRAME_W - 1) begin
      mx = 0;
      my = (my == `BORDER_FRAME_H - 1) ? 0 : my + 1;
    end else begin
      mx = mx + 1;
    end
  endtask

  function automatic logic [31:0] expected_value(input logic [7:0] addr);
    int k;
    int s;
    logic [31:0] v;
    k = int'(addr[5:4]);
    s = int'(addr[3:2]);
    if (addr[7:6] != 2'b00) begin
      v = '0;
    end else begin
      case (addr[1:0])
        border_pkg::FIELD_MEAN:
          v = (m_cnt[k][s] == '0) ? '0 : m_sum[k][s] / 32'(m_cnt[k][s]);
        border_pkg::FIELD_MAX:   v = 32'(m_max[k][s]);
        border_pkg::FIELD_MIN:   v = 32'(m_min[k][s]);
        default:                 v = 32'(m_cnt[k][s]);
      endcase
    end
    return v;
  endfunction

  task automatic idle(input int n);
    new_pixel = 1'b0;
    new_frame = 1'b0;
    read      = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic send_pixel(input logic [`BORDER_PIX_W-1:0] p);
    new_pixel = 1'b1;
    bg_pixel  = p;
    model_pixel(p);
    @(posedge clk);
    #DRIVE_DELAY;
    new_pixel = 1'b0;
  endtask

  // Value lands on readdata right after the sampling edge
  task automatic read_check(input logic [7:0] addr);
    logic [31:0] exp;
    exp     = expected_value(addr);
    read    = 1'b1;
    address = addr;
    @(posedge clk);
    #DRIVE_DELAY;
    read = 1'b0;
    checks++;
    if (readdata !== exp) begin
      errors++;
      $display("Mismatch at %0t: readdata (address %02h) expected %08h actual %08h",
               $time, addr, exp, readdata);
    end
  endtask

  task automatic sweep_all();
    for (int a = 0; a < 64; a++) begin
      read_check(8'(a));
    end
  endtask

  task automatic random_pixels(input int n);
    int r;
    int g;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      send_pixel(r[23:0]);
      if (r[27:24] == 4'd0) begin  // Occasional read straight after a pixel
        g = $random(seed);
        read_check({2'b00, g[5:0]});
      end
      idle(int'(r[29:28]));
    end
  endtask

  initial begin
    int          r;
    logic [1:0]  hi;
    rst_n     = 1'b0;
    new_pixel = 1'b0;
    new_frame = 1'b0;
    bg_pixel  = '0;
    address   = '0;
    read      = 1'b0;
    mx        = 0;
    my        = 0;
    model_clear();
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    sweep_all();  // Empty after reset

    random_pixels(FRAME_PIX);
    sweep_all();

    // Out-of-map reads each follow a nonzero read
    for (int i = 0; i < 8; i++) begin
      r  = $random(seed);
      hi = 2'(1 + (i % 3));
      read_check(8'h03);
      read_check({hi, r[5:0]});
    end

    // Back-to-back reads of the same address
    for (int a = 0; a < 64; a += 5) begin
      read_check(8'(a));
      read_check(8'(a));
    end

    // Raster is back at 0,0 so the pixel lands on the scale 0 top side
    r = $random(seed);
    send_pixel(r[23:0]);
    read_check(8'h03);

    random_pixels(PART_PIX);
    r         = $random(seed);
    new_frame = 1'b1;
    new_pixel = 1'b1;  // Dropped by the restart
    bg_pixel  = r[23:0];
    model_clear();
    mx = 0;
    my = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    new_frame = 1'b0;
    new_pixel = 1'b0;
    sweep_all();

    random_pixels(FRAME_PIX);
    sweep_all();

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: run did not finish within %0d time units", TIMEOUT);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: verilog/border_analyzer.sv
`include "border_cfg.svh"

module border_analyzer (
  input  logic                      clk,
  input  logic                      rst_n,
  tag_if.snk                        tag,
  input  logic [`BORDER_ADDR_W-1:0] address,
  input  logic                      read,
  output logic [31:0]               readdata
);

  logic [`BORDER_SCALES-1:0] hit [4];  // Indexed by side_e
  border_pkg::stats_t        side_stats [4];

  border_pkg::stats_t        sel;
  border_pkg::field_e        field;
  logic [`BORDER_SUM_W-1:0]  mean;
  logic [31:0]               value;

  // Route each border pixel to the sides it lies on
  always_comb begin
    logic valid;
    for (int k = 0; k < `BORDER_SCALES; k++) begin
      valid = tag.new_pixel && tag.tags[k].is_border;
      hit[border_pkg::SIDE_TOP][k]    = valid && (tag.tags[k].offset_y == 4'd0);
      hit[border_pkg::SIDE_BOTTOM][k] = valid && (tag.tags[k].offset_y == 4'd15);
      hit[border_pkg::SIDE_LEFT][k]   = valid && (tag.tags[k].offset_x == 4'd0);
      hit[border_pkg::SIDE_RIGHT][k]  = valid && (tag.tags[k].offset_x == 4'd15);
    end
  end

  for (genvar s = 0; s < 4; s++) begin : g_side
    side_accumulator u_acc (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (tag.new_frame),
      .pixel (tag.bg_pixel),
      .hit   (hit[s]),
      .scale (address[5:4]),
      .stats (side_stats[s])
    );
  end

  assign sel   = side_stats[address[3:2]];
  assign field = border_pkg::field_e'(address[1:0]);

  always_comb begin
    if (sel.count == '0)
      mean = '0;
    else
      mean = sel.sum / `BORDER_SUM_W'(sel.count);
  end

  always_comb begin
    case (field)
      border_pkg::FIELD_MEAN:  value = 32'(mean);
      border_pkg::FIELD_MAX:   value = 32'(sel.max);
      border_pkg::FIELD_MIN:   value = 32'(sel.min);
      default:                 value = 32'(sel.count);
    endcase
  end

  // Reads leave the statistics untouched
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      readdata <= '0;
    end else if (read) begin
      if (address[7:6] != 2'b00)
        readdata <= '0;  // Outside the map
      else
        readdata <= value;
    end
  end

  a_read_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(read)
  ) else $error("read strobe unknown");

endmodule

// File: verilog/border_cfg.svh
`ifndef BORDER_CFG_SVH
`define BORDER_CFG_SVH

// Frame geometry in pixels
`define BORDER_FRAME_W 96
`define BORDER_FRAME_H 80

// Tile scales, cell side is 2^k pixels at scale k
`define BORDER_SCALES 4

// Datapath widths
`define BORDER_PIX_W 24
`define BORDER_SUM_W 32
`define BORDER_CNT_W 16

// Read port
`define BORDER_ADDR_W 8

`endif

// File: verilog/border_pkg.sv
`include "border_cfg.svh"

package border_pkg;

  // Pixel position inside its tile at one scale
  typedef struct packed {
    logic [3:0] offset_x;
    logic [3:0] offset_y;
    logic       is_border;  // Tile lies fully inside the frame
  } tag_t;

  typedef enum logic [1:0] {
    SIDE_TOP    = 2'd0,
    SIDE_BOTTOM = 2'd1,
    SIDE_LEFT   = 2'd2,
    SIDE_RIGHT  = 2'd3
  } side_e;

  // Running statistics of one side at one scale
  typedef struct packed {
    logic [`BORDER_PIX_W-1:0] min;
    logic [`BORDER_PIX_W-1:0] max;
    logic [`BORDER_SUM_W-1:0] sum;
    logic [`BORDER_CNT_W-1:0] count;  // Zero means empty
  } stats_t;

  // Field select, address bits 1:0
  typedef enum logic [1:0] {
    FIELD_MEAN  = 2'd0,
    FIELD_MAX   = 2'd1,
    FIELD_MIN   = 2'd2,
    FIELD_COUNT = 2'd3
  } field_e;

endpackage

// File: verilog/border_top.sv
`include "border_cfg.svh"

module border_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      new_pixel,
  input  logic                      new_frame,
  input  logic [`BORDER_PIX_W-1:0]  bg_pixel,
  input  logic [`BORDER_ADDR_W-1:0] address,
  input  logic                      read,
  output logic [31:0]               readdata
);

  tag_if u_tag_if ();

  // Position and per-scale tags
  raster_tagger u_tagger (
    .clk       (clk),
    .rst_n     (rst_n),
    .new_pixel (new_pixel),
    .new_frame (new_frame),
    .bg_pixel  (bg_pixel),
    .tag       (u_tag_if.src)
  );

  // Side statistics and read port
  border_analyzer u_analyzer (
    .clk      (clk),
    .rst_n    (rst_n),
    .tag      (u_tag_if.snk),
    .address  (address),
    .read     (read),
    .readdata (readdata)
  );

endmodule

// File: verilog/raster_tagger.sv
`include "border_cfg.svh"

module raster_tagger (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     new_pixel,
  input  logic                     new_frame,
  input  logic [`BORDER_PIX_W-1:0] bg_pixel,
  tag_if.src                       tag
);

  localparam int X_W = $clog2(`BORDER_FRAME_W);
  localparam int Y_W = $clog2(`BORDER_FRAME_H);

  logic [X_W-1:0] x;
  logic [Y_W-1:0] y;

  logic x_last;
  logic y_last;

  assign x_last = (x == X_W'(`BORDER_FRAME_W - 1));
  assign y_last = (y == Y_W'(`BORDER_FRAME_H - 1));

  // Raster position of the pixel being presented
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x <= '0;
      y <= '0;
    end else if (new_frame) begin  // Wins over new_pixel
      x <= '0;
      y <= '0;
    end else if (new_pixel) begin
      if (x_last) begin
        x <= '0;
        y <= y_last ? '0 : y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  assign tag.new_pixel = new_pixel;
  assign tag.new_frame = new_frame;
  assign tag.bg_pixel  = bg_pixel;

  for (genvar k = 0; k < `BORDER_SCALES; k++) begin : g_scale
    // End of the tile along each axis, one past its last pixel
    logic [31:0] x_end;
    logic [31:0] y_end;

    assign x_end = ((32'(x) >> (k + 4)) + 32'd1) << (k + 4);
    assign y_end = ((32'(y) >> (k + 4)) + 32'd1) << (k + 4);

    assign tag.tags[k].offset_x  = x[k +: 4];
    assign tag.tags[k].offset_y  = y[k +: 4];
    assign tag.tags[k].is_border = (x_end <= 32'(`BORDER_FRAME_W)) &&
                                   (y_end <= 32'(`BORDER_FRAME_H));
  end

  a_in_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    (x < X_W'(`BORDER_FRAME_W)) && (y < Y_W'(`BORDER_FRAME_H))
  ) else $error("raster position outside frame");

endmodule

// File: verilog/side_accumulator.sv
`include "border_cfg.svh"

module side_accumulator (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clear,
  input  logic [`BORDER_PIX_W-1:0]   pixel,
  input  logic [`BORDER_SCALES-1:0]  hit,
  input  logic [1:0]                 scale,
  output border_pkg::stats_t         stats
);

  border_pkg::stats_t st [`BORDER_SCALES];

  // One pixel folded into a statistic
  function automatic border_pkg::stats_t add_pixel(
    input border_pkg::stats_t     s,
    input logic [`BORDER_PIX_W-1:0] p
  );
    border_pkg::stats_t r;
    r = s;
    if (s.count == '0) begin  // First sample seeds both limits
      r.min = p;
      r.max = p;
    end else begin
      if (p < s.min)
        r.min = p;
      if (p > s.max)
        r.max = p;
    end
    r.sum   = s.sum + `BORDER_SUM_W'(p);
    r.count = s.count + 1'b1;
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin  // Pixel in a clear cycle is dropped
      for (int k = 0; k < `BORDER_SCALES; k++) begin
        st[k] <= '0;
      end
    end else begin
      for (int k = 0; k < `BORDER_SCALES; k++) begin
        if (hit[k])
          st[k] <= add_pixel(st[k], pixel);
      end
    end
  end

  assign stats = st[scale];

  for (genvar k = 0; k < `BORDER_SCALES; k++) begin : g_chk
    a_no_wrap: assert property (
      @(posedge clk) disable iff (!rst_n)
      (hit[k] && !clear && (st[k].count == '1)) |=> (st[k].count != '0)
    ) else $error("count wrapped at scale %0d", k);
  end

endmodule

// File: verilog/tag_if.sv
`include "border_cfg.svh"

interface tag_if;

  logic                     new_pixel;
  logic                     new_frame;
  logic [`BORDER_PIX_W-1:0] bg_pixel;
  border_pkg::tag_t         tags [`BORDER_SCALES];  // One tag per scale

  modport src (
    output new_pixel,
    output new_frame,
    output bg_pixel,
    output tags
  );

  modport snk (
    input new_pixel,
    input new_frame,
    input bg_pixel,
    input tags
  );

endinterface
